// File: source/gpu_exec_pkg.sv
package gpu_exec_pkg;

    ////////////////////////////////////////////////////////////////////
    // warp geometry and field widths
    ////////////////////////////////////////////////////////////////////

    localparam int DATA_WIDTH  = 32;
    localparam int NUM_THREADS = 8;

    localparam int WARP_ID_W = 3;
    localparam int REG_ID_W  = 5;
    localparam int SCB_ID_W  = 2;
    localparam int ALUOP_W   = 4;

    localparam int QUEUE_DEPTH = 4;
    // free-slot counter has to hold 0..QUEUE_DEPTH
    localparam int FREE_W      = $clog2(QUEUE_DEPTH + 1);

    ////////////////////////////////////////////////////////////////////
    // alu op codes, anything above OP_SLL yields zero
    ////////////////////////////////////////////////////////////////////

    localparam logic [ALUOP_W-1:0] OP_ADD = 4'd0;  // add, imm allowed
    localparam logic [ALUOP_W-1:0] OP_SUB = 4'd1;
    localparam logic [ALUOP_W-1:0] OP_MUL = 4'd2;  // 16x16 unsigned
    localparam logic [ALUOP_W-1:0] OP_AND = 4'd3;  // imm allowed
    localparam logic [ALUOP_W-1:0] OP_OR  = 4'd4;  // imm allowed
    localparam logic [ALUOP_W-1:0] OP_XOR = 4'd5;  // imm allowed
    localparam logic [ALUOP_W-1:0] OP_SRA = 4'd6;  // shamt = imm[11:7]
    localparam logic [ALUOP_W-1:0] OP_SLL = 4'd7;  // shamt = imm[11:7]

    ////////////////////////////////////////////////////////////////////
    // queue payloads
    ////////////////////////////////////////////////////////////////////

    // register write result heading to the cdb
    typedef struct packed {
        logic [WARP_ID_W-1:0]              warp_id;
        logic [REG_ID_W-1:0]               dst;
        logic [NUM_THREADS-1:0]            mask;
        logic [NUM_THREADS*DATA_WIDTH-1:0] data;   // lane 0 in the low word
    } cdb_entry_t;

    // branch outcome for fetch and the simt stack
    typedef struct packed {
        logic [WARP_ID_W-1:0]   warp_id;
        logic [DATA_WIDTH-1:0]  target;
        logic [NUM_THREADS-1:0] taken_mask;
        logic                   divergent;
    } branch_entry_t;

endpackage

// File: source/lane_alu.sv
`timescale 1ns/1ps

module lane_alu
    import gpu_exec_pkg::*;
(
    input  logic [DATA_WIDTH-1:0] op_a,
    input  logic [DATA_WIDTH-1:0] op_b,
    input  logic [15:0]           imm,
    input  logic                  imm_valid,
    input  logic [ALUOP_W-1:0]    alu_op,
    input  logic                  lane_en,
    output logic [DATA_WIDTH-1:0] result
);

    logic [DATA_WIDTH-1:0] imm_sext;
    logic [DATA_WIDTH-1:0] opnd_b;     // second operand for add/and/or/xor
    logic [4:0]            shamt;
    logic [DATA_WIDTH-1:0] alu_out;

    assign imm_sext = {{(DATA_WIDTH-16){imm[15]}}, imm};
    assign opnd_b   = imm_valid ? imm_sext : op_b;
    assign shamt    = imm[11:7];

    always_comb begin
        case (alu_op)
            OP_ADD: begin
                alu_out = op_a + opnd_b;
            end
            OP_SUB: begin
                alu_out = op_a - op_b;  // no immediate form
            end
            OP_MUL: begin
                alu_out = op_a[15:0] * op_b[15:0];  // full 32 bit product
            end
            OP_AND: begin
                alu_out = op_a & opnd_b;
            end
            OP_OR: begin
                alu_out = op_a | opnd_b;
            end
            OP_XOR: begin
                alu_out = op_a ^ opnd_b;
            end
            OP_SRA: begin
                alu_out = $signed(op_a) >>> shamt;  // keeps the sign
            end
            OP_SLL: begin
                alu_out = op_a << shamt;
            end
            default: begin
                alu_out = '0;
            end
        endcase
    end

    // inactive thread contributes nothing
    assign result = lane_en ? alu_out : '0;

endmodule

// File: source/branch_unit.sv
`timescale 1ns/1ps

module branch_unit
    import gpu_exec_pkg::*;
(
    input  logic [NUM_THREADS*DATA_WIDTH-1:0] src1,
    input  logic [NUM_THREADS*DATA_WIDTH-1:0] src2,
    input  logic [NUM_THREADS-1:0]            active_mask,
    input  logic                              is_blt,   // low selects beq
    output logic [NUM_THREADS-1:0]            taken_mask,
    output logic                              divergent
);

    logic [NUM_THREADS-1:0] lane_eq;
    logic [NUM_THREADS-1:0] lane_lt;
    logic [NUM_THREADS-1:0] lane_cond;

    ////////////////////////////////////////////////////////////////////
    // per-lane compare
    ////////////////////////////////////////////////////////////////////

    genvar i;
    generate
        for (i = 0; i < NUM_THREADS; i++) begin : g_cmp
            logic [DATA_WIDTH-1:0] a;
            logic [DATA_WIDTH-1:0] b;

            assign a = src1[i*DATA_WIDTH +: DATA_WIDTH];
            assign b = src2[i*DATA_WIDTH +: DATA_WIDTH];

            assign lane_eq[i] = (a == b);
            assign lane_lt[i] = ($signed(a) < $signed(b));  // blt is signed
        end
    endgenerate

    assign lane_cond  = is_blt ? lane_lt : lane_eq;
    assign taken_mask = lane_cond & active_mask;

    ////////////////////////////////////////////////////////////////////
    // divergence
    ////////////////////////////////////////////////////////////////////

    // some active lanes go, some stay; an empty warp never diverges
    always_comb begin
        divergent = 1'b0;
        if (|taken_mask && (taken_mask != active_mask)) begin
            divergent = 1'b1;
        end
    end

endmodule

// File: source/result_queue.sv
`timescale 1ns/1ps

module result_queue
    import gpu_exec_pkg::*;
#(
    parameter type payload_t = logic [7:0]
) (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              push,
    input  payload_t          push_data,
    input  logic              pop_ready,
    output logic              pop_valid,
    output payload_t          pop_data,
    output logic [FREE_W-1:0] free_slots
);

    localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;

    payload_t            mem [QUEUE_DEPTH];
    logic [PTR_W-1:0]    wr_ptr;
    logic [PTR_W-1:0]    rd_ptr;
    logic [FREE_W-1:0]   count;    // entries held
    logic                pop;

    assign pop_valid  = (count != '0);
    assign pop        = pop_valid && pop_ready;
    assign pop_data   = mem[rd_ptr];  // head falls through
    assign free_slots = FREE_W'(QUEUE_DEPTH) - count;

    // storage, written only by a push
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(QUEUE_DEPTH-1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(QUEUE_DEPTH-1)) ? '0 : rd_ptr + 1'b1;
            end
            // push and pop together leave the count alone
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// File: source/exec_ctrl.sv
`timescale 1ns/1ps

module exec_ctrl
    import gpu_exec_pkg::*;
(
    input  logic                              clk,
    input  logic                              arst_n,
    // operand collector
    input  logic                              oc_valid,
    output logic                              oc_ready,
    input  logic [WARP_ID_W-1:0]              oc_warp_id,
    input  logic [NUM_THREADS-1:0]            oc_active_mask,
    input  logic [NUM_THREADS*DATA_WIDTH-1:0] oc_src1,
    input  logic [NUM_THREADS*DATA_WIDTH-1:0] oc_src2,
    input  logic [REG_ID_W-1:0]               oc_dst,
    input  logic [15:0]                       oc_imm,
    input  logic                              oc_imm_valid,
    input  logic                              oc_reg_write,
    input  logic [ALUOP_W-1:0]                oc_alu_op,
    input  logic                              oc_beq,
    input  logic                              oc_blt,
    input  logic [SCB_ID_W-1:0]               oc_scb_id,
    // lane alus
    output logic [NUM_THREADS*DATA_WIDTH-1:0] lane_src1,
    output logic [NUM_THREADS*DATA_WIDTH-1:0] lane_src2,
    output logic [15:0]                       lane_imm,
    output logic                              lane_imm_valid,
    output logic [ALUOP_W-1:0]                lane_alu_op,
    output logic [NUM_THREADS-1:0]            lane_mask,
    input  logic [NUM_THREADS*DATA_WIDTH-1:0] lane_result,
    // branch unit
    output logic                              br_is_blt,
    input  logic [NUM_THREADS-1:0]            br_taken_mask,
    input  logic                              br_divergent,
    // result queues
    output logic                              cdb_push,
    output logic                              br_push,
    output cdb_entry_t                        cdb_entry,
    output branch_entry_t                     br_entry,
    input  logic [FREE_W-1:0]                 cdb_free,
    input  logic [FREE_W-1:0]                 br_free,
    // scoreboard
    output logic                              scb_clear_valid,
    output logic [WARP_ID_W-1:0]              scb_clear_warp_id,
    output logic [SCB_ID_W-1:0]               scb_clear_id
);

    logic                              run_q;      // set once out of reset
    logic                              accept;
    logic                              ex_valid;
    logic [WARP_ID_W-1:0]              ex_warp_id;
    logic [NUM_THREADS-1:0]            ex_mask;
    logic [NUM_THREADS*DATA_WIDTH-1:0] ex_src1;
    logic [NUM_THREADS*DATA_WIDTH-1:0] ex_src2;
    logic [REG_ID_W-1:0]               ex_dst;
    logic [15:0]                       ex_imm;
    logic                              ex_imm_valid;
    logic                              ex_reg_write;
    logic [ALUOP_W-1:0]                ex_alu_op;
    logic                              ex_beq;
    logic                              ex_blt;
    logic [SCB_ID_W-1:0]               ex_scb_id;
    logic                              ex_branch;

    ////////////////////////////////////////////////////////////////////
    // issue and execute register
    ////////////////////////////////////////////////////////////////////

    // two free slots covers whatever is already sitting in execute
    assign oc_ready = run_q && (cdb_free >= FREE_W'(2)) && (br_free >= FREE_W'(2));
    assign accept   = oc_valid && oc_ready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            run_q    <= 1'b0;
            ex_valid <= 1'b0;
        end else begin
            run_q    <= 1'b1;
            ex_valid <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            ex_warp_id   <= oc_warp_id;
            ex_mask      <= oc_active_mask;
            ex_src1      <= oc_src1;
            ex_src2      <= oc_src2;
            ex_dst       <= oc_dst;
            ex_imm       <= oc_imm;
            ex_imm_valid <= oc_imm_valid;
            ex_reg_write <= oc_reg_write;
            ex_alu_op    <= oc_alu_op;
            ex_beq       <= oc_beq;
            ex_blt       <= oc_blt;
            ex_scb_id    <= oc_scb_id;
        end
    end

    // operands out to the lanes and the branch unit
    assign lane_src1      = ex_src1;
    assign lane_src2      = ex_src2;
    assign lane_imm       = ex_imm;
    assign lane_imm_valid = ex_imm_valid;
    assign lane_alu_op    = ex_alu_op;
    assign lane_mask      = ex_mask;
    assign br_is_blt      = ex_blt;

    ////////////////////////////////////////////////////////////////////
    // routing and payloads
    ////////////////////////////////////////////////////////////////////

    // reg write wins if both flags ever show up together
    assign ex_branch = (ex_beq || ex_blt) && !ex_reg_write;
    assign cdb_push  = ex_valid && ex_reg_write;
    assign br_push   = ex_valid && ex_branch;

    always_comb begin
        cdb_entry.warp_id    = ex_warp_id;
        cdb_entry.dst        = ex_dst;
        cdb_entry.mask       = ex_mask;
        cdb_entry.data       = lane_result;
        br_entry.warp_id     = ex_warp_id;
        br_entry.target      = {{(DATA_WIDTH-16){1'b0}}, ex_imm};  // zero-extended
        br_entry.taken_mask  = br_taken_mask;
        br_entry.divergent   = br_divergent;
    end

    // branches never reach the cdb, so clear their entry here
    assign scb_clear_valid   = br_push;
    assign scb_clear_warp_id = ex_warp_id;
    assign scb_clear_id      = ex_scb_id;

endmodule

// File: source/alu_exec_top.sv
`timescale 1ns/1ps

module alu_exec_top
    import gpu_exec_pkg::*;
(
    input  logic                              clk,
    input  logic                              arst_n,
    // operand collector
    input  logic                              oc_valid,
    output logic                              oc_ready,
    input  logic [WARP_ID_W-1:0]              oc_warp_id,
    input  logic [NUM_THREADS-1:0]            oc_active_mask,
    input  logic [NUM_THREADS*DATA_WIDTH-1:0] oc_src1,
    input  logic [NUM_THREADS*DATA_WIDTH-1:0] oc_src2,
    input  logic [REG_ID_W-1:0]               oc_dst,
    input  logic [15:0]                       oc_imm,
    input  logic                              oc_imm_valid,
    input  logic                              oc_reg_write,
    input  logic [ALUOP_W-1:0]                oc_alu_op,
    input  logic                              oc_beq,
    input  logic                              oc_blt,
    input  logic [SCB_ID_W-1:0]               oc_scb_id,
    // cdb
    output logic                              cdb_valid,
    input  logic                              cdb_ready,
    output logic [WARP_ID_W-1:0]              cdb_warp_id,
    output logic [REG_ID_W-1:0]               cdb_dst,
    output logic [NUM_THREADS-1:0]            cdb_mask,
    output logic [NUM_THREADS*DATA_WIDTH-1:0] cdb_data,
    // fetch / simt stack
    output logic                              br_valid,
    input  logic                              br_ready,
    output logic [WARP_ID_W-1:0]              br_warp_id,
    output logic [DATA_WIDTH-1:0]             br_target,
    output logic [NUM_THREADS-1:0]            br_taken_mask,
    output logic                              br_divergent,
    // scoreboard
    output logic                              scb_clear_valid,
    output logic [WARP_ID_W-1:0]              scb_clear_warp_id,
    output logic [SCB_ID_W-1:0]               scb_clear_id
);

    logic [NUM_THREADS*DATA_WIDTH-1:0] lane_src1;
    logic [NUM_THREADS*DATA_WIDTH-1:0] lane_src2;
    logic [15:0]                       lane_imm;
    logic                              lane_imm_valid;
    logic [ALUOP_W-1:0]                lane_alu_op;
    logic [NUM_THREADS-1:0]            lane_mask;
    logic [NUM_THREADS*DATA_WIDTH-1:0] lane_result;
    logic                              br_is_blt;
    logic [NUM_THREADS-1:0]            bu_taken_mask;
    logic                              bu_divergent;
    logic                              cdb_push;
    logic                              br_push;
    cdb_entry_t                        cdb_entry;
    cdb_entry_t                        cdb_head;
    branch_entry_t                     br_entry;
    branch_entry_t                     br_head;
    logic [FREE_W-1:0]                 cdb_free;
    logic [FREE_W-1:0]                 br_free;

    exec_ctrl u_exec_ctrl (.*, .br_taken_mask(bu_taken_mask), .br_divergent(bu_divergent));

    ////////////////////////////////////////////////////////////////////
    // datapath
    ////////////////////////////////////////////////////////////////////

    genvar i;
    generate
        for (i = 0; i < NUM_THREADS; i++) begin : g_lane
            lane_alu u_lane_alu (
                .op_a      (lane_src1[i*DATA_WIDTH +: DATA_WIDTH]),
                .op_b      (lane_src2[i*DATA_WIDTH +: DATA_WIDTH]),
                .imm       (lane_imm),
                .imm_valid (lane_imm_valid),
                .alu_op    (lane_alu_op),
                .lane_en   (lane_mask[i]),
                .result    (lane_result[i*DATA_WIDTH +: DATA_WIDTH])
            );
        end
    endgenerate

    branch_unit u_branch_unit (
        .src1        (lane_src1),
        .src2        (lane_src2),
        .active_mask (lane_mask),
        .is_blt      (br_is_blt),
        .taken_mask  (bu_taken_mask),
        .divergent   (bu_divergent)
    );

    ////////////////////////////////////////////////////////////////////
    // output queues
    ////////////////////////////////////////////////////////////////////

    result_queue #(.payload_t(cdb_entry_t)) u_cdb_queue (
        .clk(clk), .arst_n(arst_n), .push(cdb_push), .push_data(cdb_entry),
        .pop_ready(cdb_ready), .pop_valid(cdb_valid), .pop_data(cdb_head),
        .free_slots(cdb_free)
    );

    result_queue #(.payload_t(branch_entry_t)) u_br_queue (
        .clk(clk), .arst_n(arst_n), .push(br_push), .push_data(br_entry),
        .pop_ready(br_ready), .pop_valid(br_valid), .pop_data(br_head),
        .free_slots(br_free)
    );

    assign cdb_warp_id   = cdb_head.warp_id;
    assign cdb_dst       = cdb_head.dst;
    assign cdb_mask      = cdb_head.mask;
    assign cdb_data      = cdb_head.data;
    assign br_warp_id    = br_head.warp_id;
    assign br_target     = br_head.target;
    assign br_taken_mask = br_head.taken_mask;
    assign br_divergent  = br_head.divergent;

endmodule

// File: sim/tb_alu_exec_top.sv
`timescale 1ns/1ps

module tb_alu_exec_top
    import gpu_exec_pkg::*;
();

    localparam int NUM_REC = 18;
    localparam int REC_W   = 28;                 // 32-bit words per record
    localparam int TIMEOUT = 20 * NUM_REC + 100;

    logic                              clk = 1'b0;
    logic                              arst_n;
    logic                              oc_valid;
    logic                              oc_ready;
    logic [WARP_ID_W-1:0]              oc_warp_id;
    logic [NUM_THREADS-1:0]            oc_active_mask;
    logic [NUM_THREADS*DATA_WIDTH-1:0] oc_src1;
    logic [NUM_THREADS*DATA_WIDTH-1:0] oc_src2;
    logic [REG_ID_W-1:0]               oc_dst;
    logic [15:0]                       oc_imm;
    logic                              oc_imm_valid;
    logic                              oc_reg_write;
    logic [ALUOP_W-1:0]                oc_alu_op;
    logic                              oc_beq;
    logic                              oc_blt;
    logic [SCB_ID_W-1:0]               oc_scb_id;
    logic                              cdb_valid;
    logic                              cdb_ready;
    logic [WARP_ID_W-1:0]              cdb_warp_id;
    logic [REG_ID_W-1:0]               cdb_dst;
    logic [NUM_THREADS-1:0]            cdb_mask;
    logic [NUM_THREADS*DATA_WIDTH-1:0] cdb_data;
    logic                              br_valid;
    logic                              br_ready;
    logic [WARP_ID_W-1:0]              br_warp_id;
    logic [DATA_WIDTH-1:0]             br_target;
    logic [NUM_THREADS-1:0]            br_taken_mask;
    logic                              br_divergent;
    logic                              scb_clear_valid;
    logic [WARP_ID_W-1:0]              scb_clear_warp_id;
    logic [SCB_ID_W-1:0]               scb_clear_id;

    logic [31:0] vec [NUM_REC*REC_W];
    int          cdb_exp_q[$];   // record indices in issue order
    int          br_exp_q[$];
    int          scb_exp_q[$];
    int          scb_cyc_q[$];   // cycle the clear pulse is due
    int          cycle_cnt = 0;
    integer      seed = 11;

    alu_exec_top u_alu_exec_top (.*);

    always #10 clk = ~clk;

    ////////////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] word_at(input int rec, input int w);
        return vec[rec*REC_W + w];
    endfunction

    // 8 lanes starting at word w, lane 0 low
    function automatic logic [255:0] lanes_at(input int rec, input int w);
        logic [255:0] v;
        for (int l = 0; l < NUM_THREADS; l++) begin
            v[l*32 +: 32] = word_at(rec, w + l);
        end
        return v;
    endfunction

    task automatic check_val(input logic [255:0] got, input logic [255:0] exp,
                             input string what);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
            $display("Simulation finished: FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic abort_run(input string why);
        $display("%s (at %0t ns)", why, $time);
        $display("Simulation finished: FAIL");
        $fatal(1, "run aborted");
    endtask

    ////////////////////////////////////////////////////////////////////
    // sinks and timeout
    ////////////////////////////////////////////////////////////////////

    always @(posedge clk) begin : ready_gen
        integer rnd;
        rnd = $random(seed);
        cdb_ready <= rnd[0];
        br_ready  <= rnd[1];
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT) begin
            abort_run("timeout: outputs did not drain within the cycle limit");
        end
    end

    always @(negedge clk) begin : cdb_monitor
        int idx;
        if (arst_n && cdb_valid && cdb_ready) begin
            if (cdb_exp_q.size() == 0) begin
                abort_run("CDB sent an entry that no instruction asked for");
            end else begin
                idx = cdb_exp_q.pop_front();
                check_val(cdb_warp_id, word_at(idx, 0) & 32'h7, "cdb_warp_id");
                check_val(cdb_dst, word_at(idx, 0) >> 3 & 32'h1f, "cdb_dst");
                check_val(cdb_mask, word_at(idx, 0) >> 8 & 32'hff, "cdb_mask");
                check_val(cdb_data, lanes_at(idx, 18), "cdb_data");
            end
        end
    end

    always @(negedge clk) begin : br_monitor
        int idx;
        if (arst_n && br_valid && br_ready) begin
            if (br_exp_q.size() == 0) begin
                abort_run("branch queue sent an entry that no instruction asked for");
            end else begin
                idx = br_exp_q.pop_front();
                check_val(br_warp_id, word_at(idx, 0) & 32'h7, "br_warp_id");
                check_val(br_target, word_at(idx, 0) >> 16, "br_target");  // imm, zero-ext
                check_val(br_taken_mask, word_at(idx, 26), "br_taken_mask");
                check_val(br_divergent, word_at(idx, 27), "br_divergent");
            end
        end
    end

    // one pulse per branch, one cycle after acceptance
    always @(negedge clk) begin : scb_monitor
        int idx;
        if (arst_n && scb_clear_valid) begin
            if (scb_exp_q.size() == 0) begin
                abort_run("scoreboard clear pulsed without a branch in execute");
            end else begin
                idx = scb_exp_q.pop_front();
                check_val(cycle_cnt, scb_cyc_q.pop_front(), "scb clear cycle");
                check_val(scb_clear_warp_id, word_at(idx, 0) & 32'h7, "scb_clear_warp_id");
                check_val(scb_clear_id, word_at(idx, 1) >> 20 & 32'h3, "scb_clear_id");
            end
        end
    end

    ////////////////////////////////////////////////////////////////////
    // reset and stimulus
    ////////////////////////////////////////////////////////////////////

    initial begin
        logic [31:0] w0;
        logic [31:0] w1;
        arst_n         = 1'b0;
        oc_valid       = 1'b0;
        oc_warp_id     = '0;
        oc_active_mask = '0;
        oc_src1        = '0;
        oc_src2        = '0;
        oc_dst         = '0;
        oc_imm         = '0;
        oc_imm_valid   = 1'b0;
        oc_reg_write   = 1'b0;
        oc_alu_op      = '0;
        oc_beq         = 1'b0;
        oc_blt         = 1'b0;
        oc_scb_id      = '0;
        cdb_ready      = 1'b0;
        br_ready       = 1'b0;
        $readmemh("sim/alu_exec_testdata.hex", vec);

        repeat (10) begin
            @(negedge clk);
            check_val(oc_ready, 0, "oc_ready in reset");
            check_val(cdb_valid, 0, "cdb_valid in reset");
            check_val(br_valid, 0, "br_valid in reset");
            check_val(scb_clear_valid, 0, "scb_clear_valid in reset");
        end
        @(posedge clk);
        arst_n <= 1'b1;
        @(negedge clk);
        @(negedge clk);
        check_val(oc_ready, 1, "oc_ready after reset");

        for (int r = 0; r < NUM_REC; r++) begin
            w0 = word_at(r, 0);
            w1 = word_at(r, 1);
            @(posedge clk);
            oc_valid       <= 1'b1;
            oc_imm         <= w0[31:16];
            oc_active_mask <= w0[15:8];
            oc_dst         <= w0[7:3];
            oc_warp_id     <= w0[2:0];
            oc_scb_id      <= w1[21:20];
            oc_alu_op      <= w1[19:16];
            oc_blt         <= w1[12];
            oc_beq         <= w1[8];
            oc_reg_write   <= w1[4];
            oc_imm_valid   <= w1[0];
            oc_src1        <= lanes_at(r, 2);
            oc_src2        <= lanes_at(r, 10);
            @(negedge clk);
            while (!oc_ready) begin
                @(negedge clk);
            end
            // taken on the coming edge
            if (w1[4]) begin
                cdb_exp_q.push_back(r);
            end else if (w1[8] || w1[12]) begin
                br_exp_q.push_back(r);
                scb_exp_q.push_back(r);
                scb_cyc_q.push_back(cycle_cnt + 1);
            end
        end
        @(posedge clk);
        oc_valid <= 1'b0;

        while (cdb_exp_q.size() != 0 || br_exp_q.size() != 0 || scb_exp_q.size() != 0) begin
            @(negedge clk);
        end
        repeat (10) @(negedge clk);
        if (cdb_valid || br_valid) begin
            abort_run("extra entries left in the output queues");
        end else begin
            $display("Simulation finished: PASS");
            $finish;
        end
    end

endmodule

// File: sim/alu_exec_testdata.hex
// per record, line 1: {imm,mask,dst<<3|warp} {scb,op,blt,beq,reg_write,imm_valid} src1 lanes 0..7
// line 2: src2 lanes 0..7; line 3: expected cdb data lanes 0..7, taken mask, divergent
0000A519 00000010 00000005 FFFFFFFE 7FFFFFFF 80000000 12345678 0000FFFF 00010003 F0F0F0F0
00000003 00000007 00000001 80000000 0000000F 00000002 FFFF0004 0F0F0F0F
00000008 00000000 80000000 00000000 00000000 00010001 00000000 FFFFFFFF 00000000 00000000
0000FF22 00010010 00000005 FFFFFFFE 7FFFFFFF 80000000 12345678 0000FFFF 00010003 F0F0F0F0
00000003 00000007 00000001 80000000 0000000F 00000002 FFFF0004 0F0F0F0F
00000002 FFFFFFF7 7FFFFFFE 00000000 12345669 0000FFFD 0001FFFF E1E1E1E1 00000000 00000000
0000FF2B 00020010 00000005 FFFFFFFE 7FFFFFFF 80000000 12345678 0000FFFF 00010003 F0F0F0F0
00000003 00000007 00000001 80000000 0000000F 00000002 FFFF0004 0F0F0F0F
0000000F 0006FFF2 0000FFFF 00000000 00051108 0001FFFE 0000000C 0E2C2E10 00000000 00000000
0000FF34 00030010 00000005 FFFFFFFE 7FFFFFFF 80000000 12345678 0000FFFF 00010003 F0F0F0F0
00000003 00000007 00000001 80000000 0000000F 00000002 FFFF0004 0F0F0F0F
00000001 00000006 00000001 80000000 00000008 00000002 00010000 00000000 00000000 00000000
0000FF3D 00040010 00000005 FFFFFFFE 7FFFFFFF 80000000 12345678 0000FFFF 00010003 F0F0F0F0
00000003 00000007 00000001 80000000 0000000F 00000002 FFFF0004 0F0F0F0F
00000007 FFFFFFFF 7FFFFFFF 80000000 1234567F 0000FFFF FFFF0007 FFFFFFFF 00000000 00000000
0000FF46 00050010 00000005 FFFFFFFE 7FFFFFFF 80000000 12345678 0000FFFF 00010003 F0F0F0F0
00000003 00000007 00000001 80000000 0000000F 00000002 FFFF0004 0F0F0F0F
00000006 FFFFFFF9 7FFFFFFE 00000000 12345677 0000FFFD FFFE0007 FFFFFFFF 00000000 00000000
0200FF4F 00060010 00000005 FFFFFFFE 7FFFFFFF 80000000 12345678 0000FFFF 00010003 F0F0F0F0
00000003 00000007 00000001 80000000 0000000F 00000002 FFFF0004 0F0F0F0F
00000000 FFFFFFFF 07FFFFFF F8000000 01234567 00000FFF 00001000 FF0F0F0F 00000000 00000000
F47FFF50 00070010 00000005 FFFFFFFE 7FFFFFFF 80000000 12345678 0000FFFF 00010003 F0F0F0F0
00000003 00000007 00000001 80000000 0000000F 00000002 FFFF0004 0F0F0F0F
00000500 FFFFFE00 FFFFFF00 00000000 34567800 00FFFF00 01000300 F0F0F000 00000000 00000000
FFF0FF59 00000011 00000005 FFFFFFFE 7FFFFFFF 80000000 12345678 0000FFFF 00010003 F0F0F0F0
00000003 00000007 00000001 80000000 0000000F 00000002 FFFF0004 0F0F0F0F
FFFFFFF5 FFFFFFEE 7FFFFFEF 7FFFFFF0 12345668 0000FFEF 0000FFF3 F0F0F0E0 00000000 00000000
00FF0F62 00030011 00000005 FFFFFFFE 7FFFFFFF 80000000 12345678 0000FFFF 00010003 F0F0F0F0
00000003 00000007 00000001 80000000 0000000F 00000002 FFFF0004 0F0F0F0F
00000005 000000FE 000000FF 00000000 00000000 00000000 00000000 00000000 00000000 00000000
8000FF6B 00040011 00000005 FFFFFFFE 7FFFFFFF 80000000 12345678 0000FFFF 00010003 F0F0F0F0
00000003 00000007 00000001 80000000 0000000F 00000002 FFFF0004 0F0F0F0F
FFFF8005 FFFFFFFE FFFFFFFF FFFF8000 FFFFD678 FFFFFFFF FFFF8003 FFFFF0F0 00000000 00000000
0F0FFF74 00050011 00000005 FFFFFFFE 7FFFFFFF 80000000 12345678 0000FFFF 00010003 F0F0F0F0
00000003 00000007 00000001 80000000 0000000F 00000002 FFFF0004 0F0F0F0F
00000F0A FFFFF0F1 7FFFF0F0 80000F0F 12345977 0000F0F0 00010F0C F0F0FFFF 00000000 00000000
0000FFFD 00090010 00000005 FFFFFFFE 7FFFFFFF 80000000 12345678 0000FFFF 00010003 F0F0F0F0
00000003 00000007 00000001 80000000 0000000F 00000002 FFFF0004 0F0F0F0F
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
1234FF06 00100100 00000005 FFFFFFFE 7FFFFFFF 80000000 12345678 0000FFFF 00010003 F0F0F0F0
00000003 00000007 00000001 80000000 0000000F 00000002 FFFF0004 0F0F0F0F
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000008 00000001
ABCDFF07 00201000 00000005 FFFFFFFE 7FFFFFFF 80000000 12345678 0000FFFF 00010003 F0F0F0F0
00000003 00000007 00000001 80000000 0000000F 00000002 FFFF0004 0F0F0F0F
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000082 00000001
00407D00 00301000 00000005 FFFFFFFE 7FFFFFFF 80000000 12345678 0000FFFF 00010003 F0F0F0F0
00000003 00000007 00000001 80000000 0000000F 00000002 FFFF0004 0F0F0F0F
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
80003C03 00100100 00000005 FFFFFFFE 7FFFFFFF 80000000 12345678 0000FFFF 00010003 F0F0F0F0
00000005 FFFFFFFE 7FFFFFFF 80000000 12345678 0000FFFF 00010003 F0F0F0F0
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 0000003C 00000000
0000FF4A 00200000 00000005 FFFFFFFE 7FFFFFFF 80000000 12345678 0000FFFF 00010003 F0F0F0F0
00000003 00000007 00000001 80000000 0000000F 00000002 FFFF0004 0F0F0F0F
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000

// File: alu_exec_top.f
source/gpu_exec_pkg.sv
source/lane_alu.sv
source/branch_unit.sv
source/result_queue.sv
source/exec_ctrl.sv
source/alu_exec_top.sv
sim/tb_alu_exec_top.sv

// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing -Wno-fatal
TOP       := tb_alu_exec_top
FILELIST  := alu_exec_top.f
BUILD_DIR := obj_dir
LOG       := sim.log
SOURCES   := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	-./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Simulation finished: PASS" $(LOG); then \
		echo "run passed"; \
	else \
		echo "run failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
